// ==== src.f ====
common/sdmacPkg.sv
design/dmaFifo.sv
design/scsiDataPath.sv
scsiSm/scsiSeq.sv
scsiSm/scsiSm.sv
design/scsiDmaTop.sv
test/scsiChipModel.sv
test/tbScsiDma.sv

// ==== test/tbScsiDma.sv ====
/*
 Testbench for scsiDmaTop with a behavioral SCSI chip.
 Inputs change 1 time unit after the rising edge and are read back there.
 Data comes from a 16-bit Fibonacci LFSR, one step per bit.
*/
`default_nettype none

module tbScsiDma;
    import sdmacPkg::*;

    localparam int BytesMoved    = 16 + 16 + 36;
    localparam int TimeoutCycles = 40 * BytesMoved + 50 * 2 + 500;

    logic BCLK;
    logic CRESET_;
    logic dmaEn, dmaDir, cpuReq, cpuRw, hostWr, hostRd;
    byteT cpuWrData;
    longT hostWrData;
    wire  scsiDreq;
    byteT scsiDataIn;                   // Chip to DUT
    byteT cpuRdData;
    wire  cpuAck;
    longT hostRdData;
    wire  fifoFull, fifoEmpty, longReady, longNeeded;
    wire  scsiCs, scsiRe, scsiWe, scsiDack;
    byteT scsiDataOut;                  // DUT to chip
    logic offer, stop;
    logic [7:0] offerCnt;
    logic [7:0] srcIdx;
    wire  sinkValid;
    byteT sinkByte;
    byteT chipReg;

    byteT srcMem [64];                  // Bytes the chip sends
    byteT sinkLog [64];                 // Bytes the chip received
    int   srcFill;
    int   sinkCnt;
    int   dackPulses;
    int   dackWidth;
    int   errCount;
    int   checkCount;
    int   testNum;
    int   cycleCnt;
    logic [15:0] lfsr;

    scsiDmaTop dut0 (
        .BCLK(BCLK), .CRESET_(CRESET_), .dmaEn_i(dmaEn), .dmaDir_i(dmaDir),
        .cpuReq_i(cpuReq), .cpuRw_i(cpuRw), .cpuWrData_i(cpuWrData),
        .hostWr_i(hostWr), .hostWrData_i(hostWrData), .hostRd_i(hostRd),
        .scsiDreq_i(scsiDreq), .scsiData_i(scsiDataIn), .cpuRdData_o(cpuRdData),
        .cpuAck_o(cpuAck), .hostRdData_o(hostRdData), .fifoFull_o(fifoFull),
        .fifoEmpty_o(fifoEmpty), .hostLongReady_o(longReady),
        .hostLongNeeded_o(longNeeded), .scsiCs_o(scsiCs), .scsiRe_o(scsiRe),
        .scsiWe_o(scsiWe), .scsiDack_o(scsiDack), .scsiData_o(scsiDataOut)
    );

    scsiChipModel chip0 (
        .BCLK(BCLK), .CRESET_(CRESET_), .scsiCs_i(scsiCs), .scsiRe_i(scsiRe),
        .scsiWe_i(scsiWe), .scsiDack_i(scsiDack), .scsiData_i(scsiDataOut),
        .srcByte_i(srcMem[srcIdx[5:0]]), .offer_i(offer), .offerCnt_i(offerCnt),
        .stop_i(stop), .scsiDreq_o(scsiDreq), .scsiData_o(scsiDataIn),
        .srcIdx_o(srcIdx), .sinkValid_o(sinkValid), .sinkByte_o(sinkByte),
        .regVal_o(chipReg)
    );

    initial begin
        BCLK = 1'b0;
        forever #4 BCLK = ~BCLK;        // Period 8
    end

    task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic failNote(input string msg);
        $display("Failure: %s", msg);
        errCount++;
    endtask

    function automatic byteT randByte();
        logic fb;
        byteT b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1
            lfsr = {lfsr[14:0], fb};
            b    = {b[6:0], fb};
        end
        return b;
    endfunction

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge BCLK);
            #1;
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testNum++;
        $display("Test %0d %s: %s", testNum, name, (errCount == errBefore) ? "pass" : "FAIL");
    endtask

    task automatic idleOutputs();
        checkHex("scsiCs_o", scsiCs, 0);
        checkHex("scsiRe_o", scsiRe, 0);
        checkHex("scsiWe_o", scsiWe, 0);
        checkHex("scsiDack_o", scsiDack, 0);
        checkHex("cpuAck_o", cpuAck, 0);
        checkHex("hostLongReady_o", longReady, 0);
        checkHex("hostLongNeeded_o", longNeeded, 0);
        checkHex("fifoEmpty_o", fifoEmpty, 1);
    endtask

    // One register cycle; counts edges after the sampling edge up to ack
    task automatic cpuCycle(input logic rw, input byteT wr, output byteT rd);
        int n;
        int cs;
        n = 0;
        cs = 0;
        cpuRw = rw;
        cpuWrData = wr;
        cpuReq = 1'b1;
        while (!cpuAck && n < 50) begin
            tick(1);
            n++;
            if (scsiCs) cs++;
        end
        if (!cpuAck) failNote("cpuAck_o never rose");
        rd = cpuRdData;
        checkHex("cpuAck_o latency", n - 1, 4);
        checkHex("scsiCs_o cycles", cs, 2);
        cpuReq = 1'b0;
        tick(1);
        checkHex("cpuAck_o after release", cpuAck, 0);
        tick(2);
    endtask

    task automatic offerBytes(input int n);
        offerCnt = n[7:0];
        offer = 1'b1;
        tick(1);
        offer = 1'b0;
    endtask

    task automatic hostReadPulse();
        hostRd = 1'b1;
        tick(1);
        hostRd = 1'b0;
    endtask

    // Bus-level monitor
    always @(posedge BCLK) begin
        if (CRESET_) begin
            if (scsiCs && scsiWe) checkHex("scsiData_o", scsiDataOut, cpuWrData);
            if (cpuAck && cpuRw) checkHex("cpuRdData_o", cpuRdData, chipReg);
            if (scsiDack && scsiCs) failNote("DACK and CS high together");
            if (scsiDack) begin
                if (dackWidth == 0) dackPulses++;
                dackWidth++;
            end else begin
                if (dackWidth != 0) checkHex("DACK width", dackWidth, 2);
                dackWidth = 0;
            end
            if (sinkValid) begin
                sinkLog[sinkCnt[5:0]] = sinkByte;
                sinkCnt++;
            end
        end
    end

    always @(posedge BCLK) begin
        cycleCnt++;
        if (cycleCnt >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, run stopped", cycleCnt);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int e;
        int base;
        byteT b;
        byteT wrVal;
        byteT rdVal;
        longT expLong [4];
        longT w;
        CRESET_ = 1'b0;
        dmaEn = 0;
        dmaDir = 0;
        cpuReq = 0;
        cpuRw = 0;
        hostWr = 0;
        hostRd = 0;
        cpuWrData = '0;
        hostWrData = '0;
        offer = 0;
        stop = 0;
        offerCnt = '0;
        srcFill = 0;
        sinkCnt = 0;
        dackPulses = 0;
        dackWidth = 0;
        errCount = 0;
        checkCount = 0;
        testNum = 0;
        cycleCnt = 0;
        lfsr = 16'd4444;
        for (int i = 0; i < 64; i++) srcMem[i] = byteT'(i);

        e = errCount;                               // Reset
        repeat (4) begin
            @(posedge BCLK);
            #1;
            idleOutputs();
        end
        CRESET_ = 1'b1;
        tick(3);
        idleOutputs();
        finishTest("reset", e);

        e = errCount;                               // CPU write
        wrVal = randByte();
        cpuCycle(1'b0, wrVal, rdVal);
        checkHex("chip register", chipReg, wrVal);
        finishTest("cpu register write", e);

        e = errCount;                               // CPU read
        cpuCycle(1'b1, 8'h00, rdVal);
        checkHex("cpuRdData_o", rdVal, wrVal);
        finishTest("cpu register read", e);

        e = errCount;                               // SCSI to FIFO
        base = srcFill;
        for (int i = 0; i < 16; i++) begin
            b = randByte();
            srcMem[srcFill] = b;
            srcFill++;
        end
        dmaDir = DirS2f;
        dmaEn = 1'b1;
        offerBytes(16);
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < 300 && !longReady; n++) tick(1);
            if (!longReady) failNote("hostLongReady_o never set");
            w = {srcMem[base + 4*k], srcMem[base + 4*k + 1],
                 srcMem[base + 4*k + 2], srcMem[base + 4*k + 3]};
            checkHex("hostRdData_o", hostRdData, w);
            hostReadPulse();
        end
        dmaEn = 1'b0;
        tick(4);
        checkHex("fifoEmpty_o", fifoEmpty, 1);
        finishTest("scsi to fifo", e);

        e = errCount;                               // FIFO to SCSI
        dmaDir = DirF2s;
        dmaEn = 1'b1;
        offerBytes(16);
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                b = randByte();
                w = {w[23:0], b};                   // First byte ends up in the MSB
            end
            expLong[k] = w;
            hostWrData = w;
            hostWr = 1'b1;
            tick(1);
            hostWr = 1'b0;
            for (int n = 0; n < 300 && !longNeeded; n++) tick(1);
            if (!longNeeded) failNote("hostLongNeeded_o never rose");
            tick(1);                                // Last byte reaches the log one edge later
            checkHex("bytes logged", sinkCnt, 4 * (k + 1));
        end
        for (int i = 0; i < 16; i++) begin
            checkHex("logged byte", sinkLog[i], expLong[i / 4][31 - 8 * (i % 4) -: 8]);
        end
        dmaEn = 1'b0;
        tick(4);
        finishTest("fifo to scsi", e);

        e = errCount;                               // Full back-off
        base = srcFill;
        for (int i = 0; i < 40; i++) begin
            b = randByte();
            srcMem[srcFill] = b;
            srcFill++;
        end
        dackPulses = 0;
        dmaDir = DirS2f;
        dmaEn = 1'b1;
        offerBytes(40);
        for (int n = 0; n < 1400 && !fifoFull; n++) tick(1);
        if (!fifoFull) failNote("fifoFull_o never went high");
        tick(40);
        checkHex("DACK pulses", dackPulses, 32);
        checkHex("fifoFull_o", fifoFull, 1);
        checkHex("hostRdData_o", hostRdData,
                 {srcMem[base], srcMem[base + 1], srcMem[base + 2], srcMem[base + 3]});
        hostReadPulse();
        for (int n = 0; n < 300 && dackPulses < 36; n++) tick(1);
        tick(40);
        checkHex("DACK pulses", dackPulses, 36);
        checkHex("fifoFull_o", fifoFull, 1);
        stop = 1'b1;
        tick(1);
        stop = 1'b0;
        dmaEn = 1'b0;
        tick(4);
        finishTest("full back-off", e);

        $display("Summary: %0d tests, %0d checks, %0d errors", testNum, checkCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/scsiChipModel.sv ====
/*
 Behavioral SCSI chip for the DMA testbench. One register, one DREQ line.
 DREQ comes back 3 cycles after DACK falls while bytes remain.
 Source bytes come in from outside by index; received bytes leave as pulses.
*/
`default_nettype none

module scsiChipModel
    import sdmacPkg::*;
(
    input  wire  BCLK,
    input  wire  CRESET_,
    input  wire  scsiCs_i,
    input  wire  scsiRe_i,
    input  wire  scsiWe_i,
    input  wire  scsiDack_i,
    input  wire  byteT scsiData_i,      // Bus from the DUT
    input  wire  byteT srcByte_i,       // Source byte at srcIdx_o
    input  wire  offer_i,               // Start a run of offerCnt_i bytes
    input  wire  [7:0] offerCnt_i,
    input  wire  stop_i,                // Drop DREQ and forget the rest
    output logic scsiDreq_o,
    output byteT scsiData_o,            // Bus to the DUT
    output logic [7:0] srcIdx_o,
    output logic sinkValid_o,           // One received byte
    output byteT sinkByte_o,
    output byteT regVal_o
);

    logic       dreqR;
    logic [7:0] remaining;              // Bytes still to move
    logic [1:0] gap;                    // Cycles since DACK fell
    logic [1:0] dackCnt;                // Cycles of the current DACK

    assign #1 scsiDreq_o  = dreqR;
    assign #1 scsiData_o  = (scsiCs_i && scsiRe_i) ? regVal_o : srcByte_i;

    always @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            dreqR       <= 1'b0;
            remaining   <= '0;
            gap         <= '0;
            dackCnt     <= '0;
            srcIdx_o    <= '0;
            sinkValid_o <= 1'b0;
            sinkByte_o  <= '0;
            regVal_o    <= '0;
        end else begin
            sinkValid_o <= 1'b0;
            if (scsiCs_i && scsiWe_i) begin
                regVal_o <= scsiData_i;             // Register write
            end
            if (stop_i) begin
                remaining <= '0;
                dreqR     <= 1'b0;
            end else if (offer_i) begin
                remaining <= offerCnt_i;
                dreqR     <= (offerCnt_i != 0);
                gap       <= '0;
            end else if (scsiDack_i) begin
                dreqR   <= 1'b0;                    // Request answered
                dackCnt <= dackCnt + 1'b1;
                gap     <= '0;
                if (dackCnt == 2'd1) begin          // Last DACK cycle
                    remaining <= remaining - 1'b1;
                    if (scsiRe_i) begin
                        srcIdx_o <= srcIdx_o + 1'b1;
                    end
                    if (scsiWe_i) begin
                        sinkByte_o  <= scsiData_i;
                        sinkValid_o <= 1'b1;
                    end
                end
            end else begin
                dackCnt <= '0;
                if (remaining != 0 && !dreqR) begin
                    if (gap == 2'd2) begin
                        dreqR <= 1'b1;              // Third cycle after DACK
                        gap   <= '0;
                    end else begin
                        gap <= gap + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/scsiDmaTop.sv ====
/*
 SCSI DMA controller top. All logic runs on BCLK.
 Host FIFO port has no back-pressure; watch fifoFull_o and fifoEmpty_o.
 SCSI side uses a level DREQ/DACK handshake and a CS register cycle.
*/
`default_nettype none

module scsiDmaTop
    import sdmacPkg::*;
(
    input  wire  BCLK,
    input  wire  CRESET_,
    input  wire  dmaEn_i,
    input  wire  dmaDir_i,          // 0 = SCSI to FIFO, 1 = FIFO to SCSI
    input  wire  cpuReq_i,
    input  wire  cpuRw_i,           // 1 = read
    input  wire  byteT cpuWrData_i,
    input  wire  hostWr_i,
    input  wire  longT hostWrData_i,
    input  wire  hostRd_i,
    input  wire  scsiDreq_i,
    input  wire  byteT scsiData_i,
    output byteT cpuRdData_o,
    output logic cpuAck_o,
    output longT hostRdData_o,
    output logic fifoFull_o,
    output logic fifoEmpty_o,
    output logic hostLongReady_o,
    output logic hostLongNeeded_o,
    output logic scsiCs_o,
    output logic scsiRe_o,
    output logic scsiWe_o,
    output logic scsiDack_o,
    output byteT scsiData_o
);

    logic incBo;            // Sequencer to FIFO strobes
    logic incNi;
    logic incNo;
    logic s2f;
    logic cpu2s;            // Sequencer to datapath selects
    logic s2cpu;
    logic boEq3;
    byteT fifoByte;         // Head lane toward the chip
    byteT scsiByte;         // Registered chip byte toward the FIFO

    scsiSm u_scsiSm (
        .BCLK             (BCLK),
        .CRESET_          (CRESET_),
        .dmaEn_i          (dmaEn_i),
        .dmaDir_i         (dmaDir_i),
        .cpuReq_i         (cpuReq_i),
        .cpuRw_i          (cpuRw_i),
        .scsiDreq_i       (scsiDreq_i),
        .hostWr_i         (hostWr_i),
        .hostRd_i         (hostRd_i),
        .fifoFull_i       (fifoFull_o),
        .fifoEmpty_i      (fifoEmpty_o),
        .boEq3_i          (boEq3),
        .scsiCs_o         (scsiCs_o),
        .scsiRe_o         (scsiRe_o),
        .scsiWe_o         (scsiWe_o),
        .scsiDack_o       (scsiDack_o),
        .cpu2s_o          (cpu2s),
        .s2cpu_o          (s2cpu),
        .s2f_o            (s2f),
        .f2s_o            (),           // Mux falls back to the FIFO lane
        .incBo_o          (incBo),
        .incNi_o          (incNi),
        .incNo_o          (incNo),
        .cpuAck_o         (cpuAck_o),
        .hostLongReady_o  (hostLongReady_o),
        .hostLongNeeded_o (hostLongNeeded_o)
    );

    dmaFifo u_dmaFifo (
        .BCLK         (BCLK),
        .CRESET_      (CRESET_),
        .hostWr_i     (hostWr_i),
        .hostWrData_i (hostWrData_i),
        .hostRd_i     (hostRd_i),
        .s2f_i        (s2f),
        .scsiByte_i   (scsiByte),
        .incBo_i      (incBo),
        .incNi_i      (incNi),
        .incNo_i      (incNo),
        .hostRdData_o (hostRdData_o),
        .fifoByte_o   (fifoByte),
        .full_o       (fifoFull_o),
        .empty_o      (fifoEmpty_o),
        .boEq3_o      (boEq3)
    );

    scsiDataPath u_scsiDataPath (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .cpu2s_i     (cpu2s),
        .s2cpu_i     (s2cpu),
        .cpuWrData_i (cpuWrData_i),
        .fifoByte_i  (fifoByte),
        .scsiData_i  (scsiData_i),
        .scsiData_o  (scsiData_o),
        .scsiByte_o  (scsiByte),
        .cpuRdData_o (cpuRdData_o)
    );

endmodule

`default_nettype wire

// ==== scsiSm/scsiSm.sv ====
/*
 SCSI sequencer wrapper. Requests pass a capture flop, every strobe
 leaves through a flop, so a request shows up two edges later.
 cpuAck_o clears on the first edge that sees cpuReq_i low.
 Host flags are sticky and cleared only by the host strobes.
*/
`default_nettype none

module scsiSm
    import sdmacPkg::*;
(
    input  wire  BCLK,
    input  wire  CRESET_,
    input  wire  dmaEn_i,
    input  wire  dmaDir_i,
    input  wire  cpuReq_i,          // Held until cpuAck_o
    input  wire  cpuRw_i,
    input  wire  scsiDreq_i,        // Level request from the chip
    input  wire  hostWr_i,          // Clears longword needed
    input  wire  hostRd_i,          // Clears longword ready
    input  wire  fifoFull_i,
    input  wire  fifoEmpty_i,
    input  wire  boEq3_i,
    output logic scsiCs_o,
    output logic scsiRe_o,
    output logic scsiWe_o,
    output logic scsiDack_o,
    output logic cpu2s_o,
    output logic s2cpu_o,
    output logic s2f_o,
    output logic f2s_o,
    output logic incBo_o,
    output logic incNi_o,
    output logic incNo_o,
    output logic cpuAck_o,          // CPU cycle termination latch
    output logic hostLongReady_o,
    output logic hostLongNeeded_o
);

    logic cDmaEn;       // Captured requests
    logic cCpuReq;
    logic cDreq;

    logic seqCs;        // Unregistered sequencer strobes
    logic seqRe;
    logic seqWe;
    logic seqDack;
    logic seqCpu2s;
    logic seqS2cpu;
    logic seqS2f;
    logic seqF2s;
    logic seqIncBo;
    logic seqIncNi;
    logic seqIncNo;
    logic seqSetAck;

    logic setAckQ;      // Registered set-ack pulse
    logic ackFb;        // Ack seen by the sequencer, covers the pulse

    assign ackFb = cpuAck_o || setAckQ;

    scsiSeq u_scsiSeq (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .dmaEn_i     (cDmaEn),
        .dmaDir_i    (dmaDir_i),
        .cpuReq_i    (cCpuReq),
        .cpuRw_i     (cpuRw_i),
        .dreq_i      (cDreq),
        .cpuAck_i    (ackFb),
        .fifoFull_i  (fifoFull_i),
        .fifoEmpty_i (fifoEmpty_i),
        .boEq3_i     (boEq3_i),
        .scsiCs_o    (seqCs),
        .scsiRe_o    (seqRe),
        .scsiWe_o    (seqWe),
        .dack_o      (seqDack),
        .cpu2s_o     (seqCpu2s),
        .s2cpu_o     (seqS2cpu),
        .s2f_o       (seqS2f),
        .f2s_o       (seqF2s),
        .incBo_o     (seqIncBo),
        .incNi_o     (seqIncNi),
        .incNo_o     (seqIncNo),
        .setAck_o    (seqSetAck)
    );

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cDmaEn     <= 1'b0;
            cCpuReq    <= 1'b0;
            cDreq      <= 1'b0;
            scsiCs_o   <= 1'b0;
            scsiRe_o   <= 1'b0;
            scsiWe_o   <= 1'b0;
            scsiDack_o <= 1'b0;
            cpu2s_o    <= 1'b0;
            s2cpu_o    <= 1'b0;
            s2f_o      <= 1'b0;
            f2s_o      <= 1'b0;
            incBo_o    <= 1'b0;
            incNi_o    <= 1'b0;
            incNo_o    <= 1'b0;
            setAckQ    <= 1'b0;
        end else begin
            cDmaEn     <= dmaEn_i;      // Capture stage
            cCpuReq    <= cpuReq_i;
            cDreq      <= scsiDreq_i;
            scsiCs_o   <= seqCs;        // Output stage
            scsiRe_o   <= seqRe;
            scsiWe_o   <= seqWe;
            scsiDack_o <= seqDack;
            cpu2s_o    <= seqCpu2s;
            s2cpu_o    <= seqS2cpu;
            s2f_o      <= seqS2f;
            f2s_o      <= seqF2s;
            incBo_o    <= seqIncBo;
            incNi_o    <= seqIncNi;
            incNo_o    <= seqIncNo;
            setAckQ    <= seqSetAck;
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpuAck_o         <= 1'b0;
            hostLongReady_o  <= 1'b0;
            hostLongNeeded_o <= 1'b0;
        end else begin
            if (!cpuReq_i) begin
                cpuAck_o <= 1'b0;               // Request release ends the cycle
            end else if (setAckQ) begin
                cpuAck_o <= 1'b1;
            end
            if (incNi_o) begin
                hostLongReady_o <= 1'b1;        // SCSI side filled a longword
            end else if (hostRd_i) begin
                hostLongReady_o <= 1'b0;
            end
            if (incNo_o) begin
                hostLongNeeded_o <= 1'b1;       // SCSI side drained a longword
            end else if (hostWr_i) begin
                hostLongNeeded_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== scsiSm/scsiSeq.sv ====
/*
 SCSI sequencer core. Inputs are expected already synchronised.
 Outputs are decoded straight from the state and must be registered
 by the wrapper. cpuAck_i has to cover the set-ack pulse in flight,
 or Idle would restart a CPU cycle that just ended.
*/
`default_nettype none

module scsiSeq
    import sdmacPkg::*;
(
    input  wire  BCLK,
    input  wire  CRESET_,
    input  wire  dmaEn_i,       // DMA enabled by host
    input  wire  dmaDir_i,      // See DirS2f / DirF2s
    input  wire  cpuReq_i,      // Captured CPU register request
    input  wire  cpuRw_i,       // 1 = read from SCSI chip
    input  wire  dreq_i,        // Captured DREQ
    input  wire  cpuAck_i,      // Cycle termination feedback
    input  wire  fifoFull_i,
    input  wire  fifoEmpty_i,
    input  wire  boEq3_i,       // Byte pointer on last lane
    output logic scsiCs_o,      // Register cycle select
    output logic scsiRe_o,      // Chip drives the bus
    output logic scsiWe_o,      // Chip samples the bus
    output logic dack_o,        // DMA acknowledge
    output logic cpu2s_o,       // CPU byte onto SCSI bus
    output logic s2cpu_o,       // Latch SCSI byte for CPU
    output logic s2f_o,         // Write SCSI byte into FIFO lane
    output logic f2s_o,         // FIFO lane onto SCSI bus
    output logic incBo_o,       // Step byte pointer
    output logic incNi_o,       // Step next-in pointer
    output logic incNo_o,       // Step next-out pointer
    output logic setAck_o       // Terminate CPU cycle
);

    scsiStateT state;
    scsiStateT nextState;

    logic dirS2f;       // Bytes flow into the FIFO
    logic dirF2s;       // Bytes flow out of the FIFO
    logic cpuPending;   // New CPU request, previous one closed
    logic dmaReady;     // DREQ with room in the current direction

    assign dirS2f = (dmaDir_i == DirS2f);
    assign dirF2s = (dmaDir_i == DirF2s);
    assign cpuPending = cpuReq_i && !cpuAck_i;
    assign dmaReady = dmaEn_i && dreq_i &&
                      ((dirS2f && !fifoFull_i) || (dirF2s && !fifoEmpty_i));

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (cpuPending) begin         // CPU wins over DMA
                    nextState = CpuAccess;
                end else if (dmaReady) begin
                    nextState = DmaXfer1;
                end
            end
            CpuAccess:  nextState = CpuTerm;
            CpuTerm:    nextState = Idle;     // Ack feedback holds off a rerun
            DmaXfer1:   nextState = DmaXfer2;
            DmaXfer2:   nextState = DmaRecover;
            DmaRecover: nextState = Idle;
            default:    nextState = Idle;
        endcase
    end

    always_comb begin
        scsiCs_o = 1'b0;
        scsiRe_o = 1'b0;
        scsiWe_o = 1'b0;
        dack_o   = 1'b0;
        cpu2s_o  = 1'b0;
        s2cpu_o  = 1'b0;
        s2f_o    = 1'b0;
        f2s_o    = 1'b0;
        incBo_o  = 1'b0;
        incNi_o  = 1'b0;
        incNo_o  = 1'b0;
        setAck_o = 1'b0;
        case (state)
            CpuAccess: begin
                scsiCs_o = 1'b1;
                scsiRe_o = cpuRw_i;
                scsiWe_o = !cpuRw_i;
                cpu2s_o  = !cpuRw_i;        // Drive write byte early
            end
            CpuTerm: begin
                scsiCs_o = 1'b1;
                scsiRe_o = cpuRw_i;
                scsiWe_o = !cpuRw_i;
                cpu2s_o  = !cpuRw_i;
                s2cpu_o  = cpuRw_i;         // Read byte captured at the end
                setAck_o = 1'b1;
            end
            DmaXfer1: begin
                dack_o   = 1'b1;
                scsiRe_o = dirS2f;
                scsiWe_o = dirF2s;
                f2s_o    = dirF2s;
            end
            DmaXfer2: begin
                dack_o   = 1'b1;
                scsiRe_o = dirS2f;
                scsiWe_o = dirF2s;
                f2s_o    = dirF2s;
                s2f_o    = dirS2f;          // Lane write on the last DACK cycle
                incBo_o  = 1'b1;
                incNi_o  = dirS2f && boEq3_i;   // Longword complete
                incNo_o  = dirF2s && boEq3_i;   // Longword drained
            end
            default: begin
                // Idle and DmaRecover keep every strobe low
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/scsiDataPath.sv ====
/*
 SCSI byte datapath. The chip must drive scsiData_i within one cycle
 of RE rising; the byte is taken on the middle edge of the RE window.
 The CPU read latch holds its value until the next register read.
*/
`default_nettype none

module scsiDataPath
    import sdmacPkg::*;
(
    input  wire  BCLK,
    input  wire  CRESET_,
    input  wire  cpu2s_i,           // CPU write cycle owns the bus
    input  wire  s2cpu_i,           // Load CPU read latch
    input  wire  byteT cpuWrData_i,
    input  wire  byteT fifoByte_i,  // Current FIFO lane
    input  wire  byteT scsiData_i,  // From the chip
    output byteT scsiData_o,        // To the chip
    output byteT scsiByte_o,        // Registered chip byte
    output byteT cpuRdData_o
);

    // Outgoing bus, FIFO lane unless a CPU write is running
    assign scsiData_o = cpu2s_i ? cpuWrData_i : fifoByte_i;

    always_ff @(posedge BCLK) begin
        scsiByte_o <= scsiData_i;           // Sampled every cycle
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpuRdData_o <= '0;
        end else if (s2cpu_i) begin
            cpuRdData_o <= scsiByte_o;      // Valid while cpuAck_o is high
        end
    end

endmodule

`default_nettype wire

// ==== design/dmaFifo.sv ====
/*
 Eight-longword FIFO between the host and the SCSI byte stream.
 One byte pointer is shared by both directions; lane 0 is the MSB.
 A push while full or a pop while empty is dropped without notice.
 Host and SCSI pushes in the same cycle count as a single push.
*/
`default_nettype none

module dmaFifo
    import sdmacPkg::*;
(
    input  wire  BCLK,
    input  wire  CRESET_,
    input  wire  hostWr_i,          // Push a whole longword
    input  wire  longT hostWrData_i,
    input  wire  hostRd_i,          // Pop the head longword
    input  wire  s2f_i,             // Write SCSI byte into current lane
    input  wire  byteT scsiByte_i,
    input  wire  incBo_i,           // Next byte lane
    input  wire  incNi_i,           // SCSI side completed a longword
    input  wire  incNo_i,           // SCSI side consumed a longword
    output longT hostRdData_o,      // Head entry, always visible
    output byteT fifoByte_o,        // Current lane of the head entry
    output logic full_o,
    output logic empty_o,
    output logic boEq3_o            // Last lane selected
);

    longT    mem [FifoDepth];       // Payload, no reset
    fifoPtrT nextIn;
    fifoPtrT nextOut;
    bytePtrT bytePtr;
    fifoCntT count;

    logic       push;               // Accepted next-in step
    logic       pop;                // Accepted next-out step
    logic [4:0] laneLsb;            // Bit offset of the current lane

    assign full_o  = (count == fifoCntT'(FifoDepth));
    assign empty_o = (count == '0);
    assign boEq3_o = (bytePtr == LastLane);

    assign push    = (hostWr_i || incNi_i) && !full_o;
    assign pop     = (hostRd_i || incNo_i) && !empty_o;
    assign laneLsb = {~bytePtr, 3'b000};    // Lane 0 sits at bit 24

    assign hostRdData_o = mem[nextOut];
    assign fifoByte_o   = mem[nextOut][laneLsb +: 8];

    always_ff @(posedge BCLK) begin
        if (hostWr_i && !full_o) begin
            mem[nextIn] <= hostWrData_i;
        end else if (s2f_i && !full_o) begin
            mem[nextIn][laneLsb +: 8] <= scsiByte_i;   // Fill entry byte by byte
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            nextIn  <= '0;
            nextOut <= '0;
            bytePtr <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                nextIn <= nextIn + 1'b1;
            end
            if (pop) begin
                nextOut <= nextOut + 1'b1;
            end
            if (incBo_i) begin
                bytePtr <= bytePtr + 1'b1;              // Wraps after lane 3
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // None or both
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== common/sdmacPkg.sv ====
/*
 Shared sizes and types for the SCSI DMA sequencer.
 FIFO longwords are packed big-endian, so byte lane 0 is bits 31:24.
 dmaDir_i low moves SCSI bytes into the FIFO and high moves them out.
*/
`default_nettype none

package sdmacPkg;

    typedef logic [7:0]  byteT;     // SCSI data byte
    typedef logic [31:0] longT;     // FIFO longword
    typedef logic [2:0]  fifoPtrT;  // FIFO entry index
    typedef logic [3:0]  fifoCntT;  // Occupancy, 0 up to FifoDepth
    typedef logic [1:0]  bytePtrT;  // Byte lane inside a longword

    localparam int FifoDepth = 8;           // Longword entries
    localparam bytePtrT LastLane = 2'd3;    // Lane that completes a longword

    // Direction encoding of dmaDir_i
    localparam logic DirS2f = 1'b0;         // SCSI chip to FIFO
    localparam logic DirF2s = 1'b1;         // FIFO to SCSI chip

    typedef enum logic [2:0] {
        Idle,           // Waiting for CPU request or DREQ
        CpuAccess,      // Register cycle, first strobe cycle
        CpuTerm,        // Register cycle, second strobe cycle, sets ack
        DmaXfer1,       // DACK, first cycle
        DmaXfer2,       // DACK, byte moves here
        DmaRecover      // DACK low gap
    } scsiStateT;

endpackage

`default_nettype wire
